// ==== logic/aes128_pkg.sv ====
`default_nettype none

package aes128_pkg;

    ////////////////////
    // Types
    ////////////////////

    // Data block, AES state or full round key
    typedef logic [127:0] block_t;
    // One state column or one key word
    typedef logic [31:0]  word_t;
    // One state byte
    typedef logic [7:0]   byte_t;
    // Round number, 0 to 10
    typedef logic [3:0]   round_t;

    typedef enum logic [1:0] {
        IDLE,
        ROUND,
        DONE
    } ctrl_state_t;

    // Operands of one column unit
    typedef struct packed {
        word_t state_col;
        word_t key_word;
    } col_in_t;

    ////////////////////
    // Constants
    ////////////////////

    localparam int    NUM_ROUNDS = 10;
    // State is 4x4 bytes, so also the row count
    localparam int    NUM_COLS   = 4;
    localparam byte_t RCON_INIT  = 8'h01;

    // Forward S-box, entry 0 in the top byte
    localparam logic [0:255][7:0] SBOX = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    ////////////////////
    // Functions
    ////////////////////

    // Single byte substitution
    function automatic byte_t sbox_byte(input byte_t b);
        return SBOX[b];
    endfunction

    // Substitute all four bytes of a word
    function automatic word_t sub_word(input word_t w);
        return {sbox_byte(w[31:24]),
                sbox_byte(w[23:16]),
                sbox_byte(w[15:8]),
                sbox_byte(w[7:0])};
    endfunction

    // Multiply by x in GF(2^8)
    // Reduction by x^8 + x^4 + x^3 + x + 1
    function automatic byte_t xtime(input byte_t b);
        byte_t shifted_b;
        shifted_b = {b[6:0], 1'b0};
        if (b[7]) begin
            shifted_b = shifted_b ^ 8'h1b;
        end
        return shifted_b;
    endfunction

endpackage

`default_nettype wire

// ==== logic/aes128_column.sv ====
`timescale 1ns/1ps
`default_nettype none

// One state column per round, fully combinational
module aes128_column
    import aes128_pkg::*;
(
    input  wire col_in_t col_in,
    input  wire          last_round,
    output word_t        col_out
);

    // Column after SubBytes
    word_t sub_col;
    // Column after MixColumns
    word_t mix_col;

    // Substituted bytes, row 0 first
    byte_t a0, a1, a2, a3;
    // Doubled bytes
    byte_t d0, d1, d2, d3;

    assign sub_col = sub_word(col_in.state_col);
    assign {a0, a1, a2, a3} = sub_col;

    assign d0 = xtime(a0);
    assign d1 = xtime(a1);
    assign d2 = xtime(a2);
    assign d3 = xtime(a3);

    // Circulant matrix 02 03 01 01
    // Times 3 is the doubled byte XOR the byte itself
    assign mix_col[31:24] = d0 ^ d1 ^ a1 ^ a2 ^ a3;
    assign mix_col[23:16] = a0 ^ d1 ^ d2 ^ a2 ^ a3;
    assign mix_col[15:8]  = a0 ^ a1 ^ d2 ^ d3 ^ a3;
    assign mix_col[7:0]   = d0 ^ a0 ^ a1 ^ a2 ^ d3;

    // Round 10 has no MixColumns
    // AddRoundKey on either path
    assign col_out = (last_round ? sub_col : mix_col) ^ col_in.key_word;

endmodule

`default_nettype wire

// ==== logic/aes128_key_schedule.sv ====
`timescale 1ns/1ps
`default_nettype none

// On-the-fly AES-128 key expansion, one round key per advance
module aes128_key_schedule
    import aes128_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire block_t key_in,
    input  wire         load,
    input  wire         advance,
    output block_t      round_key
);

    // Previous round key, round key 0 right after load
    block_t key_q;
    // Round constant for the next expansion step
    byte_t  rcon_q;

    // Words of the stored key
    word_t w0, w1, w2, w3;
    // RotWord, SubWord and Rcon applied to the last word
    word_t temp;

    assign {w0, w1, w2, w3} = key_q;

    assign temp = sub_word({w3[23:0], w3[31:24]}) ^ {rcon_q, 24'h000000};

    // Chained XORs give all four new words in one step
    // Columns see round key r during round r
    assign round_key[127:96] = w0 ^ temp;
    assign round_key[95:64]  = w1 ^ w0 ^ temp;
    assign round_key[63:32]  = w2 ^ w1 ^ w0 ^ temp;
    assign round_key[31:0]   = w3 ^ w2 ^ w1 ^ w0 ^ temp;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_q  <= '0;
            rcon_q <= '0;
        end else if (load) begin
            // Cipher key is round key 0
            key_q  <= key_in;
            rcon_q <= RCON_INIT;
        end else if (advance) begin
            key_q  <= round_key;
            // 01 02 04 ... 80 1b 36, no round number needed
            rcon_q <= xtime(rcon_q);
        end
    end

endmodule

`default_nettype wire

// ==== logic/aes128_state_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

// AES state register with whitening and ShiftRows routing
module aes128_state_reg
    import aes128_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire block_t data_in,
    input  wire block_t key_in,
    input  wire         load,
    input  wire         advance,
    input  wire block_t round_out,
    output block_t      shifted,
    output block_t      data_out
);

    block_t state_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= '0;
        end else if (load) begin
            // Round 0 AddRoundKey
            state_q <= data_in ^ key_in;
        end else if (advance) begin
            // Result of the four column units
            state_q <= round_out;
        end
    end

    // ShiftRows, row r rotates left by r columns
    // Byte 4c+r takes the byte of row r from column c+r
    // Done ahead of SubBytes since the two commute
    always_comb begin
        for (int c = 0; c < NUM_COLS; c++) begin
            for (int r = 0; r < NUM_COLS; r++) begin
                shifted[127 - 8*(NUM_COLS*c + r) -: 8] =
                    state_q[127 - 8*(NUM_COLS*((c + r) % NUM_COLS) + r) -: 8];
            end
        end
    end

    // Valid while ready is high
    assign data_out = state_q;

endmodule

`default_nettype wire

// ==== logic/aes128_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

// Handshake and round sequencing
module aes128_ctrl
    import aes128_pkg::*;
(
    input  wire  clk,
    input  wire  rst_n,
    input  wire  start,
    output logic load,
    output logic advance,
    output logic last_round,
    output logic ready
);

    ctrl_state_t state_q;
    // Round being computed, 1 to NUM_ROUNDS, 0 outside ROUND
    round_t      round_cnt;

    ////////////////////
    // Decoded outputs
    ////////////////////

    // Accept only from IDLE, so one cycle wide
    assign load       = (state_q == IDLE) && start;
    assign advance    = (state_q == ROUND);
    // Counter is cleared on leaving ROUND
    assign last_round = (round_cnt == round_t'(NUM_ROUNDS));
    // Held until the host drops start
    assign ready      = (state_q == DONE);

    ////////////////////
    // FSM
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= IDLE;
            round_cnt <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    // Whitening happens on this edge
                    if (load) begin
                        state_q   <= ROUND;
                        round_cnt <= round_t'(1);
                    end
                end

                ROUND: begin
                    // One full round per cycle
                    if (last_round) begin
                        state_q   <= DONE;
                        round_cnt <= '0;
                    end else begin
                        round_cnt <= round_cnt + round_t'(1);
                    end
                end

                DONE: begin
                    // Result waits as long as start is held
                    if (!start) begin
                        state_q <= IDLE;
                    end
                end

                default: begin
                    state_q   <= IDLE;
                    round_cnt <= '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/aes128_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// Iterative AES-128 encryption core, one round per cycle
module aes128_top
    import aes128_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire         start,
    input  wire block_t data_in,
    input  wire block_t key_in,
    output block_t      data_out,
    output logic        ready
);

    // Control strobes
    logic   load;
    logic   advance;
    logic   last_round;

    // Column loop
    block_t round_key;
    block_t shifted;
    // Driven slice by slice from the column units
    wire block_t round_out;

    aes128_ctrl aes128_ctrl_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .load       (load),
        .advance    (advance),
        .last_round (last_round),
        .ready      (ready)
    );

    aes128_key_schedule aes128_key_schedule_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .key_in    (key_in),
        .load      (load),
        .advance   (advance),
        .round_key (round_key)
    );

    aes128_state_reg aes128_state_reg_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .data_in   (data_in),
        .key_in    (key_in),
        .load      (load),
        .advance   (advance),
        .round_out (round_out),
        .shifted   (shifted),
        .data_out  (data_out)
    );

    ////////////////////
    // Column units
    ////////////////////

    // Column c pairs with key word c
    for (genvar c = 0; c < NUM_COLS; c++) begin : g_col
        col_in_t col_in;

        assign col_in = '{state_col: shifted[127 - 32*c -: 32],
                          key_word:  round_key[127 - 32*c -: 32]};

        aes128_column aes128_column_inst (
            .col_in     (col_in),
            .last_round (last_round),
            .col_out    (round_out[127 - 32*c -: 32])
        );
    end

endmodule

`default_nettype wire

// ==== dv/aes128_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

// Handshake checks on the AES core boundary
module aes128_properties
    import aes128_pkg::*;
(
    input wire         clk,
    input wire         rst_n,
    input wire         start,
    input wire         ready,
    input wire block_t data_out
);

    // Count of failed assertions
    int error_cnt = 0;

    ////////////////////
    // Handshake
    ////////////////////

    // Host must drop start before the core drops ready
    assert property (@(posedge clk) disable iff (!rst_n)
        $fell(ready) |-> $past(!start))
        else begin
            $error("ready fell while start was still high");
            error_cnt++;
        end

    // Held result
    assert property (@(posedge clk) disable iff (!rst_n)
        (ready && $past(ready)) |-> $stable(data_out))
        else begin
            $error("data_out changed while ready was high");
            error_cnt++;
        end

    // No result without a request
    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ready) |-> start)
        else begin
            $error("ready rose while start was low");
            error_cnt++;
        end

endmodule

// Attach to every instance of the core
bind aes128_top aes128_properties aes128_properties_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .ready    (ready),
    .data_out (data_out)
);

`default_nettype wire

// ==== dv/aes128_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module aes128_tb
    import aes128_pkg::*;
();

    localparam int NUM_VECTORS  = 4;
    localparam int RESET_CYCLES = 5;
    localparam int IDLE_CYCLES  = 4;
    // Extra cycles start is held after ready
    localparam int MAX_HOLD     = 15;
    localparam int RANDOM_SEED  = 25;
    // Request and accept edges plus ten rounds, hold, drop and margin per entry
    localparam int TIMEOUT_CYCLES =
        NUM_VECTORS * (11 + MAX_HOLD + 4) + RESET_CYCLES + IDLE_CYCLES;

    // One known-answer entry
    typedef struct packed {
        block_t key;
        block_t plain;
        block_t cipher;
    } vector_t;

    logic    clk = 1'b0;
    logic    rst_n;
    logic    start;
    block_t  data_in;
    block_t  key_in;
    block_t  data_out;
    logic    ready;

    vector_t vectors [NUM_VECTORS];
    int      cycle_cnt = 0;

    aes128_top aes128_top_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .data_in  (data_in),
        .key_in   (key_in),
        .data_out (data_out),
        .ready    (ready)
    );

    // 20 ns period
    always #10 clk = ~clk;

    ////////////////////
    // Reporting
    ////////////////////

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_block(input string name, input block_t got, input block_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("mismatch %s: got 0x%032h expected 0x%032h",
                                      name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_error($sformatf("mismatch %s: got 0x%h expected 0x%h",
                                      name, got, exp));
        end
    endtask

    // Run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            stop_with_error("timeout: ready never arrived within the cycle limit");
        end
    end

    // Bound handshake assertions
    always @(negedge clk) begin
        if (aes128_top_inst.aes128_properties_inst.error_cnt != 0) begin
            stop_with_error("a handshake assertion failed in the bound checker");
        end
    end

    ////////////////////
    // Vector table
    ////////////////////

    task automatic fill_vectors();
        // FIPS-197 appendix B
        vectors[0] = {128'h2b7e151628aed2a6abf7158809cf4f3c,
                      128'h3243f6a8885a308d313198a2e0370734,
                      128'h3925841d02dc09fbdc118597196a0b32};
        // FIPS-197 appendix C.1
        vectors[1] = {128'h000102030405060708090a0b0c0d0e0f,
                      128'h00112233445566778899aabbccddeeff,
                      128'h69c4e0d86a7b0430d8cdb78070b4c55a};
        // All-zero key and block
        vectors[2] = {128'h0,
                      128'h0,
                      128'h66e94bd4ef8a2c3b884cfa59ca342b2e};
        // SP 800-38A ECB-AES128 block 1
        vectors[3] = {128'h2b7e151628aed2a6abf7158809cf4f3c,
                      128'h6bc1bee22e409f96e93d7e117393172a,
                      128'h3ad77bb40d7a3660a89ecaf32466ef97};
    endtask

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin
        int latency;
        int hold;

        void'($urandom(RANDOM_SEED));
        fill_vectors();

        rst_n   <= 1'b0;
        start   <= 1'b0;
        data_in <= '0;
        key_in  <= '0;

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        // Idle core stays quiet
        repeat (IDLE_CYCLES) begin
            @(posedge clk);
            @(negedge clk);
            check_flag("ready", ready, 1'b0);
        end

        for (int i = 0; i < NUM_VECTORS; i++) begin
            // Request with stable operands
            @(posedge clk);
            start   <= 1'b1;
            data_in <= vectors[i].plain;
            key_in  <= vectors[i].key;

            // Accepting edge does the whitening only
            @(posedge clk);
            @(negedge clk);
            check_flag("ready", ready, 1'b0);

            // Count round edges until the result shows up
            latency = 0;
            while (!ready) begin
                @(posedge clk);
                latency++;
                @(negedge clk);
            end
            if (latency != NUM_ROUNDS) begin
                stop_with_error($sformatf(
                    "ready came %0d edges after start was accepted instead of %0d",
                    latency, NUM_ROUNDS));
            end
            check_block("data_out", data_out, vectors[i].cipher);

            // Result must hold under back-pressure
            hold = $urandom_range(MAX_HOLD, 0);
            repeat (hold) begin
                @(posedge clk);
                @(negedge clk);
                check_flag("ready", ready, 1'b1);
                check_block("data_out", data_out, vectors[i].cipher);
            end

            // Drop the request
            @(posedge clk);
            start <= 1'b0;
            @(negedge clk);
            check_flag("ready", ready, 1'b1);
            check_block("data_out", data_out, vectors[i].cipher);

            // ready low one edge later
            @(posedge clk);
            @(negedge clk);
            check_flag("ready", ready, 1'b0);
        end

        if (aes128_top_inst.aes128_properties_inst.error_cnt != 0) begin
            stop_with_error("a handshake assertion failed in the bound checker");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== aes128_enc.f ====
logic/aes128_pkg.sv
logic/aes128_column.sv
logic/aes128_key_schedule.sv
logic/aes128_state_reg.sv
logic/aes128_ctrl.sv
logic/aes128_top.sv
dv/aes128_properties.sv
dv/aes128_tb.sv

// ==== Bender.yml ====
package:
  name: aes128_enc

sources:
  # Shared package first, then leaf modules, then the top level
  - logic/aes128_pkg.sv
  - logic/aes128_column.sv
  - logic/aes128_key_schedule.sv
  - logic/aes128_state_reg.sv
  - logic/aes128_ctrl.sv
  - logic/aes128_top.sv

  # Verification files
  - target: test
    files:
      - dv/aes128_properties.sv
      - dv/aes128_tb.sv
